//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_dmmu_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=

.PHONY: sim clean

sim:
	$(VERILATOR) --binary --timing -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) $(VFLAGS)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD_DIR)

//--- common/dmmu_pkg.sv
`default_nettype none

package dmmu_pkg;

	// Address and page geometry
	localparam int unsigned addr_w     = 32;
	localparam int unsigned page_shift = 13;

	// Direct-mapped TLB geometry
	localparam int unsigned tlb_index_w = 6;
	localparam int unsigned tlb_sets    = 64;

	// Virtual tag covers address bits 31..19
	localparam int unsigned vpn_tag_w   = 13;
	localparam int unsigned vpn_tag_lsb = addr_w - vpn_tag_w;

	// Physical page number covers bits 31..13
	localparam int unsigned ppn_w = 19;

	// SPR match entry layout
	localparam int unsigned mr_valid_bit = 0;

	// SPR translate entry layout
	localparam int unsigned tr_ci_bit  = 1;
	localparam int unsigned tr_ure_bit = 6;
	localparam int unsigned tr_uwe_bit = 7;
	localparam int unsigned tr_sre_bit = 8;
	localparam int unsigned tr_swe_bit = 9;

	// SPR address bit picking match (0) or translate (1)
	localparam int unsigned spr_sel_bit = 8;

	// Match RAM word: {tag, valid}
	localparam int unsigned mr_w          = vpn_tag_w + 1;
	localparam int unsigned mrw_valid_bit = 0;

	// Translate RAM word: {ppn, swe, sre, uwe, ure, ci}
	localparam int unsigned tr_w       = ppn_w + 5;
	localparam int unsigned trw_ci_bit  = 0;
	localparam int unsigned trw_ure_bit = 1;
	localparam int unsigned trw_uwe_bit = 2;
	localparam int unsigned trw_sre_bit = 3;
	localparam int unsigned trw_swe_bit = 4;

	// Cache inhibit when translation is off
	localparam logic dmmu_ci_default = 1'b0;

	// Exception tags towards the CPU
	typedef enum logic [3:0] {
		dtag_none = 4'h0,
		// TLB miss
		dtag_te   = 4'hb,
		// Page fault
		dtag_pe   = 4'h9
	} dtag_e;

endpackage

`default_nettype wire

//--- dtlb/dtlb.sv
`default_nettype none

module dtlb (
	input  logic                       clk,
	input  logic                       rst,
	// Translation
	input  logic                       tlb_en_i,
	input  logic [dmmu_pkg::addr_w-1:0] vaddr_i,
	output logic                       hit_o,
	output logic [dmmu_pkg::ppn_w-1:0] ppn_o,
	output logic                       ure_o,
	output logic                       uwe_o,
	output logic                       sre_o,
	output logic                       swe_o,
	output logic                       ci_o,
	// SPR access
	input  logic                       spr_cs_i,
	input  logic                       spr_write_i,
	input  logic [dmmu_pkg::addr_w-1:0] spr_addr_i,
	input  logic [dmmu_pkg::addr_w-1:0] spr_dat_i,
	output logic [dmmu_pkg::addr_w-1:0] spr_dat_o
);
	import dmmu_pkg::*;

	logic [tlb_index_w-1:0] ram_index;
	logic                   spr_we;
	logic                   mr_we;
	logic                   tr_we;
	logic [mr_w-1:0]        mr_wdata;
	logic [tr_w-1:0]        tr_wdata;
	logic [mr_w-1:0]        mr_rdata;
	logic [tr_w-1:0]        tr_rdata;
	logic [vpn_tag_w-1:0]   vtag_q;
	logic [addr_w-1:0]      mr_spr;
	logic [addr_w-1:0]      tr_spr;

	// SPR owns the index while selected, else the virtual page
	assign ram_index = spr_cs_i ? spr_addr_i[tlb_index_w-1:0]
		: vaddr_i[page_shift +: tlb_index_w];

	// Write steered by the entry type bit
	assign spr_we = spr_cs_i & spr_write_i;
	assign mr_we  = spr_we & ~spr_addr_i[spr_sel_bit];
	assign tr_we  = spr_we & spr_addr_i[spr_sel_bit];

	// Pack SPR layout into RAM words
	assign mr_wdata = {spr_dat_i[addr_w-1 -: vpn_tag_w], spr_dat_i[mr_valid_bit]};
	assign tr_wdata = {spr_dat_i[addr_w-1 -: ppn_w],
		spr_dat_i[tr_swe_bit], spr_dat_i[tr_sre_bit],
		spr_dat_i[tr_uwe_bit], spr_dat_i[tr_ure_bit],
		spr_dat_i[tr_ci_bit]};

	dtlb_match_ram dtlb_match_ram_inst (
		.clk     (clk),
		.rst     (rst),
		.index_i (ram_index),
		.we_i    (mr_we),
		.wdata_i (mr_wdata),
		.rdata_o (mr_rdata)
	);

	dtlb_translate_ram dtlb_translate_ram_inst (
		.clk     (clk),
		.rst     (rst),
		.index_i (ram_index),
		.we_i    (tr_we),
		.wdata_i (tr_wdata),
		.rdata_o (tr_rdata)
	);

	// Virtual tag captured alongside the RAM read
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vtag_q <= '0;
		end else if (tlb_en_i) begin
			vtag_q <= vaddr_i[addr_w-1:vpn_tag_lsb];
		end
	end

	// Hit needs a valid entry and matching tag
	assign hit_o = mr_rdata[mrw_valid_bit] & (mr_rdata[mr_w-1 -: vpn_tag_w] == vtag_q);

	// Unpack translate word
	assign ppn_o = tr_rdata[tr_w-1 -: ppn_w];
	assign swe_o = tr_rdata[trw_swe_bit];
	assign sre_o = tr_rdata[trw_sre_bit];
	assign uwe_o = tr_rdata[trw_uwe_bit];
	assign ure_o = tr_rdata[trw_ure_bit];
	assign ci_o  = tr_rdata[trw_ci_bit];

	// Repack into SPR layout, unimplemented bits zero
	always_comb begin
		mr_spr = '0;
		mr_spr[addr_w-1 -: vpn_tag_w] = mr_rdata[mr_w-1 -: vpn_tag_w];
		mr_spr[mr_valid_bit] = mr_rdata[mrw_valid_bit];
	end

	always_comb begin
		tr_spr = '0;
		tr_spr[addr_w-1 -: ppn_w] = tr_rdata[tr_w-1 -: ppn_w];
		tr_spr[tr_swe_bit] = tr_rdata[trw_swe_bit];
		tr_spr[tr_sre_bit] = tr_rdata[trw_sre_bit];
		tr_spr[tr_uwe_bit] = tr_rdata[trw_uwe_bit];
		tr_spr[tr_ure_bit] = tr_rdata[trw_ure_bit];
		tr_spr[tr_ci_bit]  = tr_rdata[trw_ci_bit];
	end

	// Entry type held through the two-cycle read
	assign spr_dat_o = spr_addr_i[spr_sel_bit] ? tr_spr : mr_spr;

endmodule

`default_nettype wire

//--- dtlb/dtlb_match_ram.sv
`default_nettype none

module dtlb_match_ram (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [dmmu_pkg::tlb_index_w-1:0] index_i,
	input  logic                          we_i,
	input  logic [dmmu_pkg::mr_w-1:0]     wdata_i,
	output logic [dmmu_pkg::mr_w-1:0]     rdata_o
);
	import dmmu_pkg::*;

	// Tag storage
	logic [vpn_tag_w-1:0] tag_mem [tlb_sets];

	// One valid flag per set
	logic [tlb_sets-1:0] valid_q;

	// Registered read port
	logic [mr_w-1:0] rdata_q;

	// Tag write
	always_ff @(posedge clk) begin
		if (we_i) begin
			tag_mem[index_i] <= wdata_i[mr_w-1 -: vpn_tag_w];
		end
	end

	// Valid bits cleared on reset and set by SPR writes
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			valid_q <= '0;
		end else if (we_i) begin
			valid_q[index_i] <= wdata_i[mrw_valid_bit];
		end
	end

	// Read register
	// Write data bypasses into it so the next read sees it
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rdata_q <= '0;
		end else if (we_i) begin
			rdata_q <= wdata_i;
		end else begin
			rdata_q <= {tag_mem[index_i], valid_q[index_i]};
		end
	end

	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- dtlb/dtlb_translate_ram.sv
`default_nettype none

module dtlb_translate_ram (
	input  logic                          clk,
	input  logic                          rst,
	input  logic [dmmu_pkg::tlb_index_w-1:0] index_i,
	input  logic                          we_i,
	input  logic [dmmu_pkg::tr_w-1:0]     wdata_i,
	output logic [dmmu_pkg::tr_w-1:0]     rdata_o
);
	import dmmu_pkg::*;

	// Translation storage
	// ppn, four permission bits and ci per set
	logic [tr_w-1:0] tr_mem [tlb_sets];

	// Registered read port
	logic [tr_w-1:0] rdata_q;

	// Write port
	always_ff @(posedge clk) begin
		if (we_i) begin
			tr_mem[index_i] <= wdata_i;
		end
	end

	// Read every cycle
	// During a write the old word comes out
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			rdata_q <= '0;
		end else begin
			rdata_q <= tr_mem[index_i];
		end
	end

	// Read data one cycle after the index
	assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- logic/dmmu_top.sv
`default_nettype none

module dmmu_top (
	input  logic                        clk,
	input  logic                        rst,
	// CPU side
	input  logic                        dc_en_i,
	input  logic                        dmmu_en_i,
	input  logic                        supv_i,
	input  logic [dmmu_pkg::addr_w-1:0] dcpu_adr_i,
	input  logic                        dcpu_cycstb_i,
	input  logic                        dcpu_we_i,
	output dmmu_pkg::dtag_e             dcpu_tag_o,
	output logic                        dcpu_err_o,
	// SPR side
	input  logic                        spr_cs_i,
	input  logic                        spr_write_i,
	input  logic [dmmu_pkg::addr_w-1:0] spr_addr_i,
	input  logic [dmmu_pkg::addr_w-1:0] spr_dat_i,
	output logic [dmmu_pkg::addr_w-1:0] spr_dat_o,
	// Cache side
	input  logic                        qmem_err_i,
	input  dmmu_pkg::dtag_e             qmem_tag_i,
	output logic [dmmu_pkg::addr_w-1:0] qmem_adr_o,
	output logic                        qmem_cycstb_o,
	output logic                        qmem_ci_o
);
	import dmmu_pkg::*;

	logic                   tlb_en;
	logic                   done_q;
	logic                   tlb_hit;
	logic [ppn_w-1:0]       tlb_ppn;
	logic                   tlb_ure;
	logic                   tlb_uwe;
	logic                   tlb_sre;
	logic                   tlb_swe;
	logic                   tlb_ci;
	logic [addr_w-1:0]      tlb_spr_dat;
	logic                   perm_ok;
	logic                   miss;
	logic                   fault;
	logic                   abort;
	logic [ppn_w-1:0]       vpn_q;
	logic [page_shift-1:0]  offset;

	// Look up only for a real translated request
	assign tlb_en = dmmu_en_i & dcpu_cycstb_i;

	dtlb dtlb_inst (
		.clk         (clk),
		.rst         (rst),
		.tlb_en_i    (tlb_en),
		.vaddr_i     (dcpu_adr_i),
		.hit_o       (tlb_hit),
		.ppn_o       (tlb_ppn),
		.ure_o       (tlb_ure),
		.uwe_o       (tlb_uwe),
		.sre_o       (tlb_sre),
		.swe_o       (tlb_swe),
		.ci_o        (tlb_ci),
		.spr_cs_i    (spr_cs_i),
		.spr_write_i (spr_write_i),
		.spr_addr_i  (spr_addr_i),
		.spr_dat_i   (spr_dat_i),
		.spr_dat_o   (tlb_spr_dat)
	);

	// Translation done one cycle after lookup starts
	// Stays up while the CPU holds the request
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			done_q <= 1'b0;
		end else begin
			done_q <= tlb_en;
		end
	end

	// Permission for current mode and direction
	always_comb begin
		case ({supv_i, dcpu_we_i})
			// User load
			2'b00: perm_ok = tlb_ure;
			// User store
			2'b01: perm_ok = tlb_uwe;
			// Supervisor load
			2'b10: perm_ok = tlb_sre;
			// Supervisor store
			default: perm_ok = tlb_swe;
		endcase
	end

	// Exceptions only once RAM data is valid
	assign miss  = done_q & ~tlb_hit;
	assign fault = done_q & ~perm_ok;
	assign abort = miss | fault;

	// Miss wins over fault, else cache tag passes
	assign dcpu_tag_o = miss ? dtag_te : fault ? dtag_pe : qmem_tag_i;
	assign dcpu_err_o = abort | qmem_err_i;

	// Uncached translated access waits for done
	// Cached or untranslated goes out at once and may be cut later
	assign qmem_cycstb_o = (~dc_en_i & dmmu_en_i) ? ~abort & done_q & dcpu_cycstb_i
		: ~abort & dcpu_cycstb_i;

	// Cache inhibit from the entry, default when off
	assign qmem_ci_o = dmmu_en_i ? done_q & tlb_ci : dmmu_ci_default;

	// Page number delayed a cycle for disabled mode
	// Cache expects it after the offset
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vpn_q <= '0;
		end else begin
			vpn_q <= dcpu_adr_i[addr_w-1:page_shift];
		end
	end

	// Offset is never translated
	assign offset = dcpu_adr_i[page_shift-1:0];

	// Physical address
	assign qmem_adr_o = dmmu_en_i ? {tlb_ppn, offset} : {vpn_q, offset};

	// SPR read data only while selected
	assign spr_dat_o = spr_cs_i ? tlb_spr_dat : '0;

endmodule

`default_nettype wire

//--- project.f
common/dmmu_pkg.sv
dtlb/dtlb_match_ram.sv
dtlb/dtlb_translate_ram.sv
dtlb/dtlb.sv
logic/dmmu_top.sv
verification/tb_dmmu_top.sv

//--- verification/tb_dmmu_top.sv
`default_nettype none

module tb_dmmu_top;
	timeunit 1ns;
	timeprecision 1ps;
	import dmmu_pkg::*;

	logic        clk;
	logic        rst;
	logic        dc_en;
	logic        dmmu_en;
	logic        supv;
	logic [31:0] dcpu_adr;
	logic        dcpu_cycstb;
	logic        dcpu_we;
	dtag_e       dcpu_tag;
	logic        dcpu_err;
	logic        spr_cs;
	logic        spr_write;
	logic [31:0] spr_addr;
	logic [31:0] spr_dat_in;
	logic [31:0] spr_dat_out;
	logic        qmem_err;
	dtag_e       qmem_tag;
	logic [31:0] qmem_adr;
	logic        qmem_cycstb;
	logic        qmem_ci;

	// Shadow TLB in SPR layout
	logic [31:0] mr_shadow [64];
	logic [31:0] tr_shadow [64];
	// Model of done and of the delayed page number
	logic        ref_done;
	logic [18:0] ref_vpn;
	// Comparisons enabled this cycle
	logic        check_xlate;
	logic        check_spr_read;
	logic        check_spr_idle;

	logic [31:0] lfsr_q;
	string       test_name;
	int          tests;
	int          checks = 0;
	int          errors = 0;
	int          wait_fails;
	int          checks_at_start;
	int          errors_at_start;
	int          waits_at_start;

	dmmu_top dmmu_top_inst (
		.clk           (clk),
		.rst           (rst),
		.dc_en_i       (dc_en),
		.dmmu_en_i     (dmmu_en),
		.supv_i        (supv),
		.dcpu_adr_i    (dcpu_adr),
		.dcpu_cycstb_i (dcpu_cycstb),
		.dcpu_we_i     (dcpu_we),
		.dcpu_tag_o    (dcpu_tag),
		.dcpu_err_o    (dcpu_err),
		.spr_cs_i      (spr_cs),
		.spr_write_i   (spr_write),
		.spr_addr_i    (spr_addr),
		.spr_dat_i     (spr_dat_in),
		.spr_dat_o     (spr_dat_out),
		.qmem_err_i    (qmem_err),
		.qmem_tag_i    (qmem_tag),
		.qmem_adr_o    (qmem_adr),
		.qmem_cycstb_o (qmem_cycstb),
		.qmem_ci_o     (qmem_ci)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Done follows any cycle with a translated request
	always @(posedge clk or posedge rst) begin
		if (rst) begin
			ref_done <= 1'b0;
			ref_vpn <= '0;
		end else begin
			ref_done <= dmmu_en & dcpu_cycstb;
			ref_vpn <= dcpu_adr[31:13];
		end
	end

	// Fibonacci LFSR, taps 32 22 2 1, one step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	// Expected outputs packed as
	// {ci_known, adr_known, ci, tag, err, stb, adr}
	function automatic logic [40:0] expected_outputs();
		logic [31:0] mr;
		logic [31:0] tr;
		logic [3:0]  perm;
		logic [1:0]  mode;
		logic        hit;
		logic [31:0] adr;
		logic [3:0]  tag;
		logic        stb;
		logic        err;
		logic        ci;
		logic        adr_known;
		logic        ci_known;
		mr = mr_shadow[dcpu_adr[18:13]];
		tr = tr_shadow[dcpu_adr[18:13]];
		// Untranslated defaults with cache response passing through
		adr = {ref_vpn, dcpu_adr[12:0]};
		stb = dcpu_cycstb;
		err = qmem_err;
		tag = qmem_tag;
		ci = dmmu_ci_default;
		adr_known = 1'b1;
		ci_known = 1'b1;
		if (dmmu_en) begin
			adr = {tr[31:13], dcpu_adr[12:0]};
			if (!ref_done) begin
				// Lookup cycle, RAM data not ready
				adr_known = 1'b0;
				ci = 1'b0;
				stb = dc_en & dcpu_cycstb;
			end else begin
				hit = mr[0] && (mr[31:19] == dcpu_adr[31:19]);
				// Enables indexed by {supv, we}
				perm = {tr[9], tr[8], tr[7], tr[6]};
				mode = {supv, dcpu_we};
				ci = tr[1];
				if (!hit) begin
					stb = 1'b0;
					err = 1'b1;
					tag = dtag_te;
					adr_known = 1'b0;
					ci_known = 1'b0;
				end else if (!perm[mode]) begin
					stb = 1'b0;
					err = 1'b1;
					tag = dtag_pe;
				end
			end
		end
		return {ci_known, adr_known, ci, tag, err, stb, adr};
	endfunction

	task automatic compare_value(input string what, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual) begin
			errors++;
			$display("[ERROR] %s: %s expected %h actual %h", test_name, what, expected, actual);
		end
	endtask

	// Outputs sampled mid cycle, well clear of both edges
	always @(negedge clk) begin
		logic [40:0] exp_out;
		if (check_xlate) begin
			exp_out = expected_outputs();
			compare_value("qmem_cycstb_o", 32'(exp_out[32]), 32'(qmem_cycstb));
			compare_value("dcpu_err_o", 32'(exp_out[33]), 32'(dcpu_err));
			compare_value("dcpu_tag_o", 32'(exp_out[37:34]), 32'(dcpu_tag));
			if (exp_out[39])
				compare_value("qmem_adr_o", exp_out[31:0], qmem_adr);
			if (exp_out[40])
				compare_value("qmem_ci_o", 32'(exp_out[38]), 32'(qmem_ci));
		end
		if (check_spr_read)
			compare_value("spr_dat_o", spr_addr[8] ? tr_shadow[spr_addr[5:0]]
				: mr_shadow[spr_addr[5:0]], spr_dat_out);
		if (check_spr_idle)
			compare_value("spr_dat_o idle", 32'h0, spr_dat_out);
	end

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic start_test(input string name);
		test_name = name;
		tests++;
		checks_at_start = checks;
		errors_at_start = errors;
		waits_at_start = wait_fails;
	endtask

	task automatic end_test();
		$display("%s: %0d checks, %0d errors", test_name, checks - checks_at_start,
			errors - errors_at_start + wait_fails - waits_at_start);
	endtask

	task automatic spr_write_entry(input logic sel, input logic [5:0] idx,
		input logic [31:0] data);
		spr_cs = 1'b1;
		spr_write = 1'b1;
		spr_addr = {23'h0, sel, 2'b00, idx};
		spr_dat_in = data;
		next_cycle();
		spr_cs = 1'b0;
		spr_write = 1'b0;
		// Keep only implemented bits
		if (sel)
			tr_shadow[idx] = data & 32'hffff_e3c2;
		else
			mr_shadow[idx] = data & 32'hfff8_0001;
	endtask

	// Two-cycle select, data checked in the second, then zero when idle
	task automatic spr_read_entry(input logic sel, input logic [5:0] idx);
		spr_cs = 1'b1;
		spr_write = 1'b0;
		spr_addr = {23'h0, sel, 2'b00, idx};
		next_cycle();
		check_spr_read = 1'b1;
		next_cycle();
		check_spr_read = 1'b0;
		spr_cs = 1'b0;
		check_spr_idle = 1'b1;
		next_cycle();
		check_spr_idle = 1'b0;
	endtask

	// perm is {swe, sre, uwe, ure}
	task automatic load_entry(input logic [5:0] idx, input logic [12:0] tag, input logic valid,
		input logic [18:0] ppn, input logic [3:0] perm, input logic ci);
		spr_write_entry(1'b0, idx, {tag, 18'h0, valid});
		spr_write_entry(1'b1, idx, {ppn, 3'h0, perm, 4'h0, ci, 1'b0});
	endtask

	task automatic cache_response();
		logic [31:0] r;
		r = random_bits(3);
		qmem_err = r[2];
		case (r[1:0])
			2'd1: qmem_tag = dtag_te;
			2'd2: qmem_tag = dtag_pe;
			default: qmem_tag = dtag_none;
		endcase
	endtask

	task automatic drive_request(input logic [31:0] vaddr, input logic we, input logic sv,
		input logic dce);
		cache_response();
		dmmu_en = 1'b1;
		dc_en = dce;
		supv = sv;
		dcpu_we = we;
		dcpu_adr = vaddr;
		dcpu_cycstb = 1'b1;
		check_xlate = 1'b1;
	endtask

	// Drop the request and leave one idle cycle
	task automatic release_request();
		check_xlate = 1'b0;
		dcpu_cycstb = 1'b0;
		next_cycle();
	endtask

	task automatic run_request(input logic [31:0] vaddr, input logic we, input logic sv,
		input logic dce);
		drive_request(vaddr, we, sv, dce);
		next_cycle();
		next_cycle();
		release_request();
	endtask

	task automatic wait_strobe();
		int cycles;
		cycles = 0;
		while (!qmem_cycstb && cycles < 8) begin
			@(negedge clk);
			cycles++;
		end
		if (!qmem_cycstb) begin
			wait_fails++;
			$display("%s: timeout, qmem_cycstb_o never rose after the request", test_name);
		end
	endtask

	task automatic test_disabled();
		logic [31:0] r;
		start_test("translation disabled");
		dmmu_en = 1'b0;
		for (int i = 0; i < 4; i++) begin
			cache_response();
			r = random_bits(2);
			dc_en = r[1];
			dcpu_cycstb = r[0];
			dcpu_adr = random_bits(32);
			check_xlate = 1'b1;
			next_cycle();
			// Address held, page number catches up
			cache_response();
			next_cycle();
			check_xlate = 1'b0;
		end
		dcpu_cycstb = 1'b0;
		end_test();
	endtask

	task automatic test_spr();
		logic [5:0] idx;
		start_test("spr access");
		for (int i = 0; i < 6; i++) begin
			idx = 6'(random_bits(6));
			spr_write_entry(1'b0, idx, random_bits(32));
			spr_write_entry(1'b1, idx, random_bits(32));
			spr_read_entry(1'b0, idx);
			spr_read_entry(1'b1, idx);
		end
		end_test();
	endtask

	task automatic test_hit_uncached();
		logic [31:0] vaddr;
		logic [31:0] r;
		logic [3:0]  perm;
		start_test("translated hit, dc_en low");
		for (int i = 0; i < 4; i++) begin
			vaddr = random_bits(32);
			r = random_bits(3);
			perm = 4'(random_bits(4));
			perm[r[1:0]] = 1'b1;
			load_entry(vaddr[18:13], vaddr[31:19], 1'b1, 19'(random_bits(19)), perm, r[2]);
			drive_request(vaddr, r[0], r[1], 1'b0);
			wait_strobe();
			next_cycle();
			release_request();
		end
		end_test();
	endtask

	task automatic test_miss();
		logic [31:0] vaddr;
		logic [31:0] r;
		start_test("tlb miss");
		for (int i = 0; i < 3; i++) begin
			vaddr = random_bits(32);
			r = random_bits(2);
			// Right tag but invalid
			load_entry(vaddr[18:13], vaddr[31:19], 1'b0, 19'(random_bits(19)), 4'hf, 1'b0);
			run_request(vaddr, r[0], r[1], 1'b0);
			// Valid but some other tag
			load_entry(vaddr[18:13], vaddr[31:19] ^ (13'(random_bits(13)) | 13'h1), 1'b1,
				19'(random_bits(19)), 4'hf, 1'b0);
			run_request(vaddr, r[0], r[1], 1'b0);
		end
		end_test();
	endtask

	task automatic test_fault();
		logic [31:0] vaddr;
		logic [1:0]  mode;
		start_test("page fault");
		vaddr = random_bits(32);
		for (int k = 0; k < 4; k++) begin
			mode = 2'(k);
			// Only the enable for this mode and direction cleared
			load_entry(vaddr[18:13], vaddr[31:19], 1'b1, 19'(random_bits(19)),
				~(4'b1 << mode), 1'b0);
			run_request(vaddr, mode[0], mode[1], 1'b0);
			load_entry(vaddr[18:13], vaddr[31:19], 1'b1, 19'(random_bits(19)),
				4'b1 << mode, 1'b1);
			run_request(vaddr, mode[0], mode[1], 1'b0);
		end
		end_test();
	endtask

	task automatic test_cached();
		logic [31:0] vaddr;
		logic [31:0] r;
		start_test("translated request, dc_en high");
		for (int i = 0; i < 3; i++) begin
			vaddr = random_bits(32);
			r = random_bits(3);
			load_entry(vaddr[18:13], vaddr[31:19], 1'b1, 19'(random_bits(19)), 4'hf, r[2]);
			run_request(vaddr, r[0], r[1], 1'b1);
			// Same set with a foreign tag, strobe cut in cycle two
			load_entry(vaddr[18:13], ~vaddr[31:19], 1'b1, 19'(random_bits(19)), 4'hf, r[2]);
			run_request(vaddr, r[0], r[1], 1'b1);
		end
		end_test();
	endtask

	initial begin
		lfsr_q = 32'h1ef8_f815;
		rst = 1'b1;
		dc_en = 1'b0;
		dmmu_en = 1'b0;
		supv = 1'b0;
		dcpu_adr = '0;
		dcpu_cycstb = 1'b0;
		dcpu_we = 1'b0;
		spr_cs = 1'b0;
		spr_write = 1'b0;
		spr_addr = '0;
		spr_dat_in = '0;
		qmem_err = 1'b0;
		qmem_tag = dtag_none;
		check_xlate = 1'b0;
		check_spr_read = 1'b0;
		check_spr_idle = 1'b0;
		tests = 0;
		wait_fails = 0;
		// Fresh TLB, every entry invalid
		for (int i = 0; i < 64; i++) begin
			mr_shadow[i] = '0;
			tr_shadow[i] = '0;
		end
		repeat (10) @(posedge clk);
		#5;
		rst = 1'b0;
		next_cycle();
		test_disabled();
		test_spr();
		test_hit_uncached();
		test_miss();
		test_fault();
		test_cached();
		$display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors + wait_fails);
		if (errors + wait_fails == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
